// File: sim.f
+incdir+tb
source/csr_pkg.sv
source/csr_req_if.sv
source/csr_trap_if.sv
source/csr_decode.sv
source/csr_regs.sv
source/trap_ctrl.sv
source/csr_unit.sv
tb/tb_csr_unit.sv

// File: Bender.yml
package:
  name: csr_unit

sources:
  - source/csr_pkg.sv
  - source/csr_req_if.sv
  - source/csr_trap_if.sv
  - source/csr_decode.sv
  - source/csr_regs.sv
  - source/trap_ctrl.sv
  - source/csr_unit.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_csr_unit.sv

// File: tb/csr_unit_tests.svh
   task automatic read_csr(logic [11:0] addr);
      send_req(csr_pkg::CSR_RS, addr, '0);    // set with zero, no store
   endtask

   task automatic take_interrupt(logic [DATA_W-1:0] epc);
      @(negedge clk_i);
      pc_i      = epc;
      ext_irq_i = 1'b1;
      @(negedge clk_i);
      check_flag("redirect_o", 1'b0, redirect_o);    // line only sampled so far
      @(negedge clk_i);
      check_flag("redirect_o", 1'b1, redirect_o);
      check_data("redirect_pc_o", model[2] & ~DATA_W'(3), redirect_pc_o);
      model[3] = epc;
      model[4] = csr_pkg::MCAUSE_MEI;
      model[0][csr_pkg::MSTATUS_MPIE] = model[0][csr_pkg::MSTATUS_MIE];
      model[0][csr_pkg::MSTATUS_MIE]  = 1'b0;
      @(negedge clk_i);
      check_flag("redirect_o", 1'b0, redirect_o);    // no second entry
   endtask

   task automatic expect_no_redirect(int cycles);
      repeat (cycles) begin
         @(negedge clk_i);
         check_flag("redirect_o", 1'b0, redirect_o);
      end
   endtask

   task automatic test_reset_values();
      int err_start;
      err_start = err_cnt;
      read_csr(csr_pkg::MSTATUS_ADDR);
      read_csr(csr_pkg::MIE_ADDR);
      read_csr(csr_pkg::MTVEC_ADDR);
      read_csr(csr_pkg::MEPC_ADDR);
      read_csr(csr_pkg::MCAUSE_ADDR);
      read_csr(csr_pkg::MIP_ADDR);
      drain();
      report_test("reset values", err_start);
   endtask

   task automatic test_operations();
      logic [11:0] addrs [3] = '{csr_pkg::MSTATUS_ADDR, csr_pkg::MIE_ADDR, csr_pkg::MTVEC_ADDR};
      int          err_start;
      err_start = err_cnt;
      foreach (addrs[i]) begin
         send_req(csr_pkg::CSR_RW, addrs[i], $random(seed));    // back to back
         send_req(csr_pkg::CSR_RS, addrs[i], $random(seed));
         send_req(csr_pkg::CSR_RC, addrs[i], $random(seed));
         read_csr(addrs[i]);
      end
      drain();
      report_test("csr operations", err_start);
   endtask

   task automatic test_illegal();
      int err_start;
      err_start = err_cnt;
      send_req(csr_pkg::CSR_RW, 12'h7c0, $random(seed));
      send_req(csr_pkg::CSR_RS, 12'h343, '1);    // mtval not implemented
      send_req(csr_pkg::CSR_RW, csr_pkg::MIP_ADDR, '1);
      read_csr(csr_pkg::MIP_ADDR);
      drain();
      report_test("illegal and read only", err_start);
   endtask

   task automatic test_irq_entry();
      int err_start;
      err_start = err_cnt;
      send_req(csr_pkg::CSR_RW, csr_pkg::MTVEC_ADDR, 32'h0000_1203);    // mode bits dropped
      send_req(csr_pkg::CSR_RS, csr_pkg::MIE_ADDR, MEIE_BIT);
      send_req(csr_pkg::CSR_RS, csr_pkg::MSTATUS_ADDR, MIE_BIT);
      drain();
      take_interrupt(32'h0000_0a48);
      read_csr(csr_pkg::MEPC_ADDR);
      read_csr(csr_pkg::MCAUSE_ADDR);
      read_csr(csr_pkg::MSTATUS_ADDR);
      read_csr(csr_pkg::MIP_ADDR);
      drain();
      ext_irq_i = 1'b0;
      report_test("interrupt entry", err_start);
   endtask

   task automatic test_mask_return();
      int err_start;
      err_start = err_cnt;
      send_req(csr_pkg::CSR_RS, csr_pkg::MIE_ADDR, MEIE_BIT);
      send_req(csr_pkg::CSR_RC, csr_pkg::MSTATUS_ADDR, MIE_BIT);
      drain();
      ext_irq_i = 1'b1;
      expect_no_redirect(10);    // global enable off
      ext_irq_i = 1'b0;
      send_req(csr_pkg::CSR_RC, csr_pkg::MIE_ADDR, MEIE_BIT);
      send_req(csr_pkg::CSR_RS, csr_pkg::MSTATUS_ADDR, MIE_BIT);
      drain();
      ext_irq_i = 1'b1;
      expect_no_redirect(10);    // external enable off
      ext_irq_i = 1'b0;
      send_req(csr_pkg::CSR_RS, csr_pkg::MIE_ADDR, MEIE_BIT);
      drain();
      take_interrupt(32'h0000_3c10);
      ext_irq_i = 1'b0;
      @(negedge clk_i);
      mret_i = 1'b1;
      @(negedge clk_i);
      mret_i = 1'b0;
      check_flag("redirect_o", 1'b1, redirect_o);
      check_data("redirect_pc_o", model[3], redirect_pc_o);
      model[0][csr_pkg::MSTATUS_MIE]  = model[0][csr_pkg::MSTATUS_MPIE];
      model[0][csr_pkg::MSTATUS_MPIE] = 1'b1;
      read_csr(csr_pkg::MSTATUS_ADDR);
      drain();
      report_test("masking and mret", err_start);
   endtask

   task automatic test_random();
      logic [11:0]        addrs [7] = '{csr_pkg::MSTATUS_ADDR, csr_pkg::MIE_ADDR,
                                        csr_pkg::MTVEC_ADDR, csr_pkg::MEPC_ADDR,
                                        csr_pkg::MCAUSE_ADDR, csr_pkg::MIP_ADDR, 12'hfff};
      csr_pkg::csr_op_e   ops [3] = '{csr_pkg::CSR_RW, csr_pkg::CSR_RS, csr_pkg::CSR_RC};
      int                 err_start;
      err_start = err_cnt;
      repeat (200) begin
         send_req(ops[$unsigned($random(seed)) % 3], addrs[$unsigned($random(seed)) % 7],
                  $random(seed));
      end
      drain();
      report_test("random sequence", err_start);
   endtask

// File: tb/tb_csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module tb_csr_unit;

   localparam int unsigned DATA_W      = 32;
   localparam int unsigned CLK_PERIOD  = 40;
   localparam int unsigned TEST_CYCLES = 3 + 9 + 15 + 7 + 18 + 46 + 203;    // reset, then each test
   localparam logic [DATA_W-1:0] MIE_BIT  = 1 << csr_pkg::MSTATUS_MIE;
   localparam logic [DATA_W-1:0] MEIE_BIT = 1 << csr_pkg::MIE_MEIE;
   localparam logic [DATA_W-1:0] MEIP_BIT = 1 << csr_pkg::MIP_MEIP;

   logic                clk_i = 1'b0;
   logic                e_intr;
   logic                ext_irq_i;
   logic                req_valid_i;
   csr_pkg::csr_op_e    req_op_i;
   logic [11:0]         req_addr_i;
   logic [DATA_W-1:0]   req_wdata_i;
   logic                mret_i;
   logic [DATA_W-1:0]   pc_i;
   logic                rsp_valid_o;
   logic [DATA_W-1:0]   rsp_rdata_o;
   logic                rsp_illegal_o;
   logic                redirect_o;
   logic [DATA_W-1:0]   redirect_pc_o;

   logic [DATA_W-1:0]   model [5] = '{default: '0};    // mstatus, mie, mtvec, mepc, mcause
   logic [DATA_W-1:0]   exp_data_q [$];
   logic                exp_ill_q [$];
   int unsigned         due_q [$];    // cycle a response is due
   int unsigned         cycle    = 0;
   int                  err_cnt  = 0;
   int                  pass_cnt = 0;
   int                  fail_cnt = 0;
   int                  seed     = 32'hd91d68b0;

   csr_unit #(.DATA_W(DATA_W)) i_csr_unit (.*);

   always #(CLK_PERIOD / 2) clk_i = ~clk_i;

   always @(posedge clk_i) cycle <= cycle + 1;

   task automatic check_data(string name, logic [DATA_W-1:0] exp, logic [DATA_W-1:0] act);
      if (act !== exp) begin
         $display("ERROR %0t %s expected %h actual %h", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic check_flag(string name, logic exp, logic act);
      if (act !== exp) begin
         $display("ERROR %0t %s expected %b actual %b", $time, name, exp, act);
         err_cnt++;
      end
   endtask

   task automatic note_failure(string what);
      $display("%0t %s", $time, what);
      err_cnt++;
   endtask

   task automatic report_test(string name, int err_start);
      if (err_cnt == err_start) begin
         pass_cnt++;
         $display("%0t test %s passed", $time, name);
      end else begin
         fail_cnt++;
         $display("%0t test %s failed with %0d errors", $time, name, err_cnt - err_start);
      end
   endtask

   function automatic int slot_of(logic [11:0] addr);
      case (addr)
         csr_pkg::MSTATUS_ADDR : return 0;
         csr_pkg::MIE_ADDR     : return 1;
         csr_pkg::MTVEC_ADDR   : return 2;
         csr_pkg::MEPC_ADDR    : return 3;
         csr_pkg::MCAUSE_ADDR  : return 4;
         csr_pkg::MIP_ADDR     : return 5;    // read only
         default               : return -1;
      endcase
   endfunction

   // drive one request on the falling edge, queue its response, update the model
   task automatic send_req(csr_pkg::csr_op_e op, logic [11:0] addr,
                           logic [DATA_W-1:0] data);
      int                  slot;
      logic [DATA_W-1:0]   old;
      @(negedge clk_i);
      slot = slot_of(addr);
      old  = (slot == 5) ? (ext_irq_i ? MEIP_BIT : '0) :
             (slot < 0)  ? '0 : model[slot];
      exp_data_q.push_back(old);
      exp_ill_q.push_back(slot < 0);
      due_q.push_back(cycle + 2);
      if (slot >= 0 && slot < 5) begin
         case (op)
            csr_pkg::CSR_RS : model[slot] = old | data;
            csr_pkg::CSR_RC : model[slot] = old & ~data;
            default         : model[slot] = data;
         endcase
      end
      req_valid_i = 1'b1;
      req_op_i    = op;
      req_addr_i  = addr;
      req_wdata_i = data;
   endtask

   task automatic drain();
      @(negedge clk_i);
      req_valid_i = 1'b0;
      repeat (2) @(negedge clk_i);    // pipeline depth
   endtask

   // each response against the oldest expectation
   always @(negedge clk_i) begin
      if (!e_intr && rsp_valid_o) begin
         if (due_q.size() == 0) begin
            note_failure("response arrived with no request outstanding");
         end else begin
            if (due_q[0] != cycle) begin
               note_failure("response arrived on the wrong cycle");
            end
            check_data("rsp_rdata_o", exp_data_q.pop_front(), rsp_rdata_o);
            check_flag("rsp_illegal_o", exp_ill_q.pop_front(), rsp_illegal_o);
            due_q.delete(0);
         end
      end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
         note_failure("expected response did not arrive");
         exp_data_q.delete(0);
         exp_ill_q.delete(0);
         due_q.delete(0);
      end
   end

`include "csr_unit_tests.svh"

   initial begin
      e_intr      = 1'b1;
      ext_irq_i   = 1'b0;
      req_valid_i = 1'b0;
      req_op_i    = csr_pkg::CSR_RW;
      req_addr_i  = '0;
      req_wdata_i = '0;
      mret_i      = 1'b0;
      pc_i        = '0;
      repeat (2) @(posedge clk_i);
      @(negedge clk_i);
      e_intr = 1'b0;
      test_reset_values();
      test_operations();
      test_illegal();
      test_irq_entry();
      test_mask_return();
      test_random();
      $display("tests passed %0d failed %0d, errors %0d", pass_cnt, fail_cnt, err_cnt);
      if (fail_cnt == 0 && err_cnt == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin
      #((TEST_CYCLES + 100) * CLK_PERIOD);    // some margin on top
      $display("watchdog expired before the tests completed");
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: source/csr_unit.sv
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
   parameter int unsigned DATA_W = 32
) (
   input  logic                  clk_i,
   input  logic                  e_intr,
   input  logic                  ext_irq_i,

   input  logic                  req_valid_i,
   input  csr_pkg::csr_op_e      req_op_i,
   input  logic [11:0]           req_addr_i,
   input  logic [DATA_W-1:0]     req_wdata_i,

   input  logic                  mret_i,
   input  logic [DATA_W-1:0]     pc_i,

   output logic                  rsp_valid_o,
   output logic [DATA_W-1:0]     rsp_rdata_o,
   output logic                  rsp_illegal_o,

   output logic                  redirect_o,
   output logic [DATA_W-1:0]     redirect_pc_o
);

   csr_req_if  #(.DATA_W(DATA_W)) req_bus ();
   csr_trap_if #(.DATA_W(DATA_W)) trap_bus ();

   csr_decode #(
      .DATA_W        (DATA_W)
   ) i_csr_decode (
      .clk_i         (clk_i),
      .e_intr        (e_intr),
      .req_valid_i   (req_valid_i),
      .req_op_i      (req_op_i),
      .req_addr_i    (req_addr_i),
      .req_wdata_i   (req_wdata_i),
      .req           (req_bus.dec)
   );

   csr_regs #(
      .DATA_W        (DATA_W)
   ) i_csr_regs (
      .clk_i         (clk_i),
      .e_intr        (e_intr),
      .ext_irq_i     (ext_irq_i),
      .req           (req_bus.rf),
      .trap          (trap_bus.rf),
      .rsp_valid_o   (rsp_valid_o),
      .rsp_rdata_o   (rsp_rdata_o),
      .rsp_illegal_o (rsp_illegal_o)
   );

   trap_ctrl #(
      .DATA_W        (DATA_W)
   ) i_trap_ctrl (
      .clk_i         (clk_i),
      .e_intr        (e_intr),
      .mret_i        (mret_i),
      .pc_i          (pc_i),
      .trap          (trap_bus.tc),
      .redirect_o    (redirect_o),
      .redirect_pc_o (redirect_pc_o)
   );

endmodule

`default_nettype wire

// File: source/trap_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module trap_ctrl #(
   parameter int unsigned DATA_W = 32
) (
   input  logic                  clk_i,
   input  logic                  e_intr,
   input  logic                  mret_i,
   input  logic [DATA_W-1:0]     pc_i,
   csr_trap_if.tc                trap,
   output logic                  redirect_o,
   output logic [DATA_W-1:0]     redirect_pc_o
);

   logic                redirect_q;
   logic [DATA_W-1:0]   redirect_pc_q;
   logic                take_irq;

   // mret wins over a pending interrupt
   assign take_irq   = trap.glob_ie && trap.ext_ie && trap.ext_ip && !mret_i;

   assign trap.enter = take_irq;
   assign trap.leave = mret_i;
   assign trap.epc   = pc_i;    // pc saved into mepc on entry

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         redirect_q <= 1'b0;
      end else begin
         redirect_q <= take_irq || mret_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (take_irq) begin
         redirect_pc_q <= {trap.mtvec[DATA_W-1:2], 2'b00};    // direct mode only
      end else if (mret_i) begin
         redirect_pc_q <= trap.mepc;
      end
   end

   assign redirect_o    = redirect_q;
   assign redirect_pc_o = redirect_pc_q;

endmodule

`default_nettype wire

// File: source/csr_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_regs #(
   parameter int unsigned DATA_W = 32
) (
   input  logic                  clk_i,
   input  logic                  e_intr,
   input  logic                  ext_irq_i,
   csr_req_if.rf                 req,
   csr_trap_if.rf                trap,
   output logic                  rsp_valid_o,
   output logic [DATA_W-1:0]     rsp_rdata_o,
   output logic                  rsp_illegal_o
);

   // interrupt bit at the msb, exception code in the low bits
   localparam logic [DATA_W-1:0] CAUSE_MEI = {1'b1, {(DATA_W-1){1'b0}}}
                                            | DATA_W'(csr_pkg::MCAUSE_MEI[30:0]);

   logic [DATA_W-1:0]   mstatus_q;
   logic [DATA_W-1:0]   mie_q;
   logic [DATA_W-1:0]   mtvec_q;
   logic [DATA_W-1:0]   mepc_q;
   logic [DATA_W-1:0]   mcause_q;
   logic                meip_q;
   logic [DATA_W-1:0]   mip_val;

   logic [DATA_W-1:0]   old_val;
   logic [DATA_W-1:0]   new_val;
   logic                wr_en;

   logic                rsp_valid_q;
   logic                rsp_illegal_q;
   logic [DATA_W-1:0]   rsp_rdata_q;

   assign mip_val = DATA_W'(meip_q) << csr_pkg::MIP_MEIP;

   always_comb begin
      case (req.idx)
         csr_pkg::IDX_MSTATUS : old_val = mstatus_q;
         csr_pkg::IDX_MIE     : old_val = mie_q;
         csr_pkg::IDX_MTVEC   : old_val = mtvec_q;
         csr_pkg::IDX_MEPC    : old_val = mepc_q;
         csr_pkg::IDX_MCAUSE  : old_val = mcause_q;
         csr_pkg::IDX_MIP     : old_val = mip_val;
         default              : old_val = '0;
      endcase
   end

   always_comb begin
      case (req.op)
         csr_pkg::CSR_RS : new_val = old_val | req.wdata;
         csr_pkg::CSR_RC : new_val = old_val & ~req.wdata;
         default         : new_val = req.wdata;
      endcase
   end

   // skip the store when the result equals the old value
   assign wr_en = req.valid && req.writable && (new_val != old_val);

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         mstatus_q <= '0;
         mie_q     <= '0;
         mtvec_q   <= '0;
         mepc_q    <= '0;
         mcause_q  <= '0;
         meip_q    <= 1'b0;
      end else begin
         meip_q <= ext_irq_i;    // level sampled every edge
         if (wr_en) begin
            case (req.idx)
               csr_pkg::IDX_MSTATUS : mstatus_q <= new_val;
               csr_pkg::IDX_MIE     : mie_q     <= new_val;
               csr_pkg::IDX_MTVEC   : mtvec_q   <= new_val;
               csr_pkg::IDX_MEPC    : mepc_q    <= new_val;
               csr_pkg::IDX_MCAUSE  : mcause_q  <= new_val;
               default              : ;
            endcase
         end
         // trap updates come last so they win over a csr write
         if (trap.enter) begin
            mepc_q                         <= trap.epc;
            mcause_q                       <= CAUSE_MEI;
            mstatus_q[csr_pkg::MSTATUS_MPIE] <= mstatus_q[csr_pkg::MSTATUS_MIE];
            mstatus_q[csr_pkg::MSTATUS_MIE]  <= 1'b0;
         end else if (trap.leave) begin
            mstatus_q[csr_pkg::MSTATUS_MIE]  <= mstatus_q[csr_pkg::MSTATUS_MPIE];
            mstatus_q[csr_pkg::MSTATUS_MPIE] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         rsp_valid_q   <= 1'b0;
         rsp_illegal_q <= 1'b0;
      end else begin
         rsp_valid_q   <= req.valid;
         rsp_illegal_q <= req.valid && (req.idx == csr_pkg::IDX_NONE);
      end
   end

   always_ff @(posedge clk_i) begin
      if (req.valid) begin
         rsp_rdata_q <= old_val;    // zero for unknown address
      end
   end

   assign rsp_valid_o   = rsp_valid_q;
   assign rsp_illegal_o = rsp_illegal_q;
   assign rsp_rdata_o   = rsp_rdata_q;

   assign trap.glob_ie = mstatus_q[csr_pkg::MSTATUS_MIE];
   assign trap.ext_ie  = mie_q[csr_pkg::MIE_MEIE];
   assign trap.ext_ip  = meip_q;
   assign trap.mtvec   = mtvec_q;
   assign trap.mepc    = mepc_q;

endmodule

`default_nettype wire

// File: source/csr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module csr_decode #(
   parameter int unsigned DATA_W = 32
) (
   input  logic                  clk_i,
   input  logic                  e_intr,
   input  logic                  req_valid_i,
   input  csr_pkg::csr_op_e      req_op_i,
   input  logic [11:0]           req_addr_i,
   input  logic [DATA_W-1:0]     req_wdata_i,
   csr_req_if.dec                req
);

   csr_pkg::csr_idx_e   idx_d;
   logic                writable_d;

   always_comb begin
      writable_d = 1'b1;
      case (req_addr_i)
         csr_pkg::MSTATUS_ADDR : idx_d = csr_pkg::IDX_MSTATUS;
         csr_pkg::MIE_ADDR     : idx_d = csr_pkg::IDX_MIE;
         csr_pkg::MTVEC_ADDR   : idx_d = csr_pkg::IDX_MTVEC;
         csr_pkg::MEPC_ADDR    : idx_d = csr_pkg::IDX_MEPC;
         csr_pkg::MCAUSE_ADDR  : idx_d = csr_pkg::IDX_MCAUSE;
         csr_pkg::MIP_ADDR     : begin
            idx_d      = csr_pkg::IDX_MIP;
            writable_d = 1'b0;    // mip follows the irq line only
         end
         default               : begin
            idx_d      = csr_pkg::IDX_NONE;
            writable_d = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk_i or posedge e_intr) begin
      if (e_intr) begin
         req.valid <= 1'b0;
      end else begin
         req.valid <= req_valid_i;
      end
   end

   // fields only matter while valid is high
   always_ff @(posedge clk_i) begin
      if (req_valid_i) begin
         req.op       <= req_op_i;
         req.idx      <= idx_d;
         req.writable <= writable_d;
         req.wdata    <= req_wdata_i;
      end
   end

endmodule

`default_nettype wire

// File: source/csr_trap_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_trap_if #(
   parameter int unsigned DATA_W = 32
);

   // state from the register file
   logic                 glob_ie;   // mstatus.MIE
   logic                 ext_ie;    // mie.MEIE
   logic                 ext_ip;    // mip.MEIP
   logic [DATA_W-1:0]    mtvec;
   logic [DATA_W-1:0]    mepc;

   // commands from trap control
   logic                 enter;
   logic                 leave;
   logic [DATA_W-1:0]    epc;

   modport rf (
      output glob_ie, ext_ie, ext_ip, mtvec, mepc,
      input  enter, leave, epc
   );

   modport tc (
      input  glob_ie, ext_ie, ext_ip, mtvec, mepc,
      output enter, leave, epc
   );

endinterface

`default_nettype wire

// File: source/csr_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface csr_req_if #(
   parameter int unsigned DATA_W = 32
);

   logic                 valid;     // one cycle strobe
   csr_pkg::csr_op_e     op;
   csr_pkg::csr_idx_e    idx;
   logic                 writable;
   logic [DATA_W-1:0]    wdata;

   modport dec (
      output valid, op, idx, writable, wdata
   );

   modport rf (
      input  valid, op, idx, writable, wdata
   );

endinterface

`default_nettype wire

// File: source/csr_pkg.sv
`default_nettype none

package csr_pkg;

   // csr instruction operation, encoded like funct3[1:0]
   typedef enum logic [1:0] {
      CSR_RW = 2'd1,
      CSR_RS = 2'd2,
      CSR_RC = 2'd3
   } csr_op_e;

   // internal register select after address decode
   typedef enum logic [2:0] {
      IDX_MSTATUS = 3'd0,
      IDX_MIE     = 3'd1,
      IDX_MTVEC   = 3'd2,
      IDX_MEPC    = 3'd3,
      IDX_MCAUSE  = 3'd4,
      IDX_MIP     = 3'd5,
      IDX_NONE    = 3'd7
   } csr_idx_e;

   // machine mode csr addresses
   localparam logic [11:0] MSTATUS_ADDR = 12'h300;
   localparam logic [11:0] MIE_ADDR     = 12'h304;
   localparam logic [11:0] MTVEC_ADDR   = 12'h305;
   localparam logic [11:0] MEPC_ADDR    = 12'h341;
   localparam logic [11:0] MCAUSE_ADDR  = 12'h342;
   localparam logic [11:0] MIP_ADDR     = 12'h344;

   // bit positions
   localparam int unsigned MSTATUS_MIE  = 3;
   localparam int unsigned MSTATUS_MPIE = 7;
   localparam int unsigned MIE_MEIE     = 11;
   localparam int unsigned MIP_MEIP     = 11;

   // machine external interrupt cause, interrupt bit plus code 11
   localparam logic [31:0] MCAUSE_MEI   = 32'h8000_000b;

endpackage

`default_nettype wire
